// ==== Makefile ====
TOOL       = verilator
TOP        = instrFrontEndTb
FILELIST   = instrFrontEnd.f
FLAGS      = --binary --assert --timing -sv -Wno-fatal
LINT_FLAGS = --lint-only --timing -sv
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== instrFrontEnd.f ====
logic/x86FrontPkg.sv
logic/wbByteFetch.sv
logic/prefixOpcodeDecode.sv
logic/gprFile.sv
logic/effAddrCalc.sv
logic/decodeCtrl.sv
logic/instrFrontEnd.sv
verif/frontEnd_asserts.sv
verif/instrFrontEndTb.sv

// ==== logic/decodeCtrl.sv ====
`timescale 1ns/1ps

module decodeCtrl (
  input  logic                     clk25,
  input  logic                     reset,
  output logic                     fetchStart,
  output x86FrontPkg::fetchReq     fetchRq,
  input  logic                     fetchDone,
  input  logic [31:0]              fetchData,
  input  x86FrontPkg::prefixState  prefix,
  output logic                     byteStrobe,
  output logic                     clearPrefix,
  output x86FrontPkg::addrByte     modrmOut,
  output x86FrontPkg::addrByte     sibOut,
  output logic [31:0]              dispOut,
  input  logic                     needSib,
  input  logic                     memOperand,
  input  logic [1:0]               dispBytes,
  output logic                     eaLoad,
  input  logic [31:0]              eaValue,
  input  logic [15:0]              segValue,
  output logic [2:0]               regSel,
  output logic [1:0]               regWidth,
  input  logic [31:0]              regData,
  output logic                     outValid,
  input  logic                     outReady,
  output x86FrontPkg::decodedInstr outInstr
);

  x86FrontPkg::frontState state;
  logic [1:0]             phase;     // Step inside a state
  logic [15:0]            ip;
  x86FrontPkg::addrByte   modrmReg;
  x86FrontPkg::addrByte   sibReg;
  logic [31:0]            dispReg;
  logic [31:0]            op1;
  logic [31:0]            op2;
  logic                   codeFetch;  // Request goes to cs:ip
  logic                   accept;
  logic                   dir;

  assign dir        = prefix.opcode[1];  // 1 = reg, r/m
  assign outValid   = state == x86FrontPkg::DONE;
  assign accept     = outValid && outReady;
  assign clearPrefix = state == x86FrontPkg::INIT || accept;
  assign byteStrobe = state == x86FrontPkg::PREFIX && phase == 2'd1 && fetchDone;
  assign eaLoad     = state == x86FrontPkg::DISP && phase == 2'd2;
  assign modrmOut   = modrmReg;
  assign sibOut     = sibReg;
  assign dispOut    = dispReg;
  assign codeFetch  = state inside {x86FrontPkg::PREFIX, x86FrontPkg::MODRM,
                                    x86FrontPkg::SIB, x86FrontPkg::DISP};

  // 8 / 16 / 32 from opcode w bit and osize
  assign regWidth = !prefix.opcode[0] ? 2'd0 : (prefix.osize ? 2'd2 : 2'd1);
  assign regSel   = phase == 2'd0 ? modrmReg.modrmF.regIdx : modrmReg.modrmF.rm;

  // ------------------------------
  // Fetch request
  // ------------------------------
  always_comb begin
    fetchRq.addr = codeFetch
      ? {x86FrontPkg::segResetVal[x86FrontPkg::segCs], 4'h0} + {4'h0, ip}
      : {segValue, 4'h0} + eaValue[19:0];  // Operand at seg:ea
    case (state)
      x86FrontPkg::DISP:   fetchRq.cntM1 = dispBytes == 2'b11 ? 2'd3 : dispBytes - 2'd1;
      x86FrontPkg::OPREAD: fetchRq.cntM1 = regWidth == 2'd2 ? 2'd3 : regWidth;
      default:             fetchRq.cntM1 = 2'd0;  // Single code byte
    endcase
    case (state)
      x86FrontPkg::PREFIX, x86FrontPkg::MODRM: fetchStart = phase == 2'd0;
      x86FrontPkg::SIB:    fetchStart = phase == 2'd0 && needSib;
      x86FrontPkg::DISP:   fetchStart = phase == 2'd0 && dispBytes != 2'b00;
      x86FrontPkg::OPREAD: fetchStart = phase == 2'd1;
      default:             fetchStart = 1'b0;
    endcase
  end

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge clk25) begin
    if (reset) begin
      state <= x86FrontPkg::INIT;
      phase <= 2'd0;
      ip    <= 16'h0000;
    end else begin
      case (state)
        x86FrontPkg::INIT: state <= x86FrontPkg::PREFIX;
        x86FrontPkg::PREFIX: begin
          if (phase == 2'd0) phase <= 2'd1;
          else if (phase == 2'd1 && fetchDone) phase <= 2'd2;
          else if (phase == 2'd2) begin
            phase <= 2'd0;
            // Opcode register took the byte, so it was no prefix
            if (prefix.opcode == fetchData[7:0])
              state <= prefix.needModrm ? x86FrontPkg::MODRM : x86FrontPkg::DONE;
          end
        end
        x86FrontPkg::MODRM: begin
          if (phase == 2'd0) phase <= 2'd1;
          else if (fetchDone) begin
            state <= x86FrontPkg::SIB;
            phase <= 2'd0;
          end
        end
        x86FrontPkg::SIB: begin
          if (phase == 2'd0 && !needSib) state <= x86FrontPkg::DISP;  // Decided on fresh ModRM
          else if (phase == 2'd0) phase <= 2'd1;
          else if (fetchDone) begin
            state <= x86FrontPkg::DISP;
            phase <= 2'd0;
          end
        end
        x86FrontPkg::DISP: begin
          if (phase == 2'd0) phase <= dispBytes != 2'b00 ? 2'd1 : 2'd2;
          else if (phase == 2'd1 && fetchDone) phase <= 2'd2;
          else if (phase == 2'd2) begin
            state <= x86FrontPkg::OPREAD;  // ea captured this cycle
            phase <= 2'd0;
          end
        end
        x86FrontPkg::OPREAD: begin
          if (phase == 2'd0) phase <= memOperand ? 2'd1 : 2'd2;
          else if (phase == 2'd1) phase <= 2'd3;
          else if (phase == 2'd2 || fetchDone) state <= x86FrontPkg::DONE;
        end
        x86FrontPkg::DONE: begin
          if (outReady) begin
            state <= x86FrontPkg::PREFIX;
            phase <= 2'd0;
          end
        end
        default: state <= x86FrontPkg::INIT;
      endcase
      if (codeFetch && phase == 2'd1 && fetchDone)
        ip <= ip + {14'd0, fetchRq.cntM1} + 16'd1;  // Past the bytes just read
    end
  end

  // ------------------------------
  // Captured bytes and operands
  // ------------------------------
  always_ff @(posedge clk25) begin
    if (clearPrefix) begin
      modrmReg <= '0;
      sibReg   <= '0;
      dispReg  <= '0;
      op1      <= '0;
      op2      <= '0;
    end else if (state == x86FrontPkg::OPREAD) begin
      if (phase == 2'd0 && dir) op1 <= regData;        // reg field
      else if (phase == 2'd0) op2 <= regData;
      else if (phase == 2'd2 && dir) op2 <= regData;   // r/m register
      else if (phase == 2'd2) op1 <= regData;
      else if (fetchDone && dir) op2 <= fetchData;     // r/m memory
      else if (fetchDone) op1 <= fetchData;
    end else if (fetchDone) begin
      if (state == x86FrontPkg::MODRM) modrmReg <= fetchData[7:0];
      if (state == x86FrontPkg::SIB) sibReg <= fetchData[7:0];
      if (state == x86FrontPkg::DISP) dispReg <= fetchData;
    end
  end

  // Record held by the registers while DONE waits
  always_comb begin
    outInstr.prefix     = prefix;
    outInstr.modrm      = modrmReg;
    outInstr.sib        = sibReg;
    outInstr.ea         = (prefix.needModrm && memOperand) ? eaValue : 32'd0;  // Memory forms only
    outInstr.segValue   = segValue;
    outInstr.memOperand = prefix.needModrm && memOperand;
    outInstr.op1        = op1;
    outInstr.op2        = op2;
    outInstr.nextIp     = ip;
  end

endmodule

// ==== logic/effAddrCalc.sv ====
`timescale 1ns/1ps

module effAddrCalc (
  input  logic                    clk25,
  input  logic                    reset,
  input  x86FrontPkg::addrByte    addrMode,
  input  x86FrontPkg::addrByte    sibByte,
  input  logic                    asize,
  input  x86FrontPkg::prefixState prefix,
  input  x86FrontPkg::gprBank     gprAll,
  input  logic [31:0]             scaledIndex,
  input  logic [31:0]             disp,
  input  logic                    eaLoad,
  output logic [1:0]              dispBytes,  // 0 none, 1 d8, 2 d16, 3 d32
  output logic [31:0]             eaValue,
  output logic [1:0]              segSelOut,
  output logic                    needSib,
  output logic                    memOperand
);

  logic [1:0]  mode;
  logic [2:0]  rm;
  logic        dispMode;   // mod 01 or 10
  logic        sibNoBase;  // SIB base 101 under mod 00
  logic        ssDefault;
  logic [15:0] base16;
  logic [31:0] base32;
  logic [31:0] dispExt;

  assign mode       = addrMode.modrmF.mode;
  assign rm         = addrMode.modrmF.rm;
  assign dispMode   = mode[1] ^ mode[0];
  assign memOperand = mode != 2'b11;
  assign needSib    = asize && memOperand && rm == 3'b100;
  assign sibNoBase  = sibByte.sibF.base == 3'b101 && mode == 2'b00;

  // ------------------------------
  // Base registers
  // ------------------------------
  always_comb begin
    case (rm)
      3'b000:  base16 = gprAll[3][15:0] + gprAll[6][15:0];  // bx+si
      3'b001:  base16 = gprAll[3][15:0] + gprAll[7][15:0];  // bx+di
      3'b010:  base16 = gprAll[5][15:0] + gprAll[6][15:0];  // bp+si
      3'b011:  base16 = gprAll[5][15:0] + gprAll[7][15:0];  // bp+di
      3'b100:  base16 = gprAll[6][15:0];
      3'b101:  base16 = gprAll[7][15:0];
      3'b110:  base16 = mode == 2'b00 ? 16'd0 : gprAll[5][15:0];  // disp16 only
      default: base16 = gprAll[3][15:0];
    endcase
    case (rm)
      3'b100:  base32 = (sibNoBase ? 32'd0 : gprAll[sibByte.sibF.base]) + scaledIndex;
      3'b101:  base32 = mode == 2'b00 ? 32'd0 : gprAll[5];  // disp32 only
      default: base32 = gprAll[rm];
    endcase
  end

  // ------------------------------
  // Displacement size and value
  // ------------------------------
  always_comb begin
    if (!memOperand) dispBytes = 2'd0;
    else if (mode == 2'b01) dispBytes = 2'd1;
    else if (!asize) dispBytes = (mode == 2'b10 || rm == 3'b110) ? 2'd2 : 2'd0;
    else if (mode == 2'b10) dispBytes = 2'd3;
    else if (rm == 3'b101 || (rm == 3'b100 && sibNoBase)) dispBytes = 2'd3;
    else dispBytes = 2'd0;
    case (dispBytes)
      2'd1:    dispExt = {{24{disp[7]}}, disp[7:0]};
      2'd2:    dispExt = {{16{disp[15]}}, disp[15:0]};
      2'd3:    dispExt = disp;
      default: dispExt = 32'd0;
    endcase
  end

  // bp and ebp based forms fall back to ss
  assign ssDefault = asize
    ? (dispMode && (rm == 3'b101 || (rm == 3'b100 && sibByte.sibF.base == 3'b101)))
    : (memOperand && rm[2:1] == 2'b01) || (dispMode && rm == 3'b110);

  assign segSelOut = prefix.segOverride ? prefix.segSel
                   : ssDefault ? x86FrontPkg::segSs : x86FrontPkg::segDs;

  always_ff @(posedge clk25) begin
    if (reset) eaValue <= 32'd0;
    else if (eaLoad) eaValue <= asize ? base32 + dispExt : {16'd0, base16 + dispExt[15:0]};
  end

endmodule

// ==== logic/gprFile.sv ====
`timescale 1ns/1ps

module gprFile (
  input  logic                 clk25,
  input  logic                 reset,
  input  logic [2:0]           regSel,
  input  logic [1:0]           width,        // 0 = 8, 1 = 16, 2 = 32
  output logic [31:0]          regData,
  input  x86FrontPkg::addrByte sibByte,
  output logic [31:0]          scaledIndex,
  input  logic [1:0]           segSel,
  output logic [15:0]          segData,
  output x86FrontPkg::gprBank  gprAll
);

  x86FrontPkg::gprBank gpr;
  x86FrontPkg::segBank seg;

  // Nothing writes back, values stay at reset contents
  always_ff @(posedge clk25) begin
    if (reset) begin
      gpr <= x86FrontPkg::gprResetVal;
      seg <= x86FrontPkg::segResetVal;
    end
  end

  always_comb begin
    case (width)
      2'd0: regData = regSel[2] ? {24'd0, gpr[{1'b0, regSel[1:0]}][15:8]}  // ah ch dh bh
                                : {24'd0, gpr[regSel][7:0]};
      2'd1:    regData = {16'd0, gpr[regSel][15:0]};
      default: regData = gpr[regSel];
    endcase
  end

  // index * 2^scale, index 100 means none
  assign scaledIndex = sibByte.sibF.index == 3'b100 ? 32'd0
                     : gpr[sibByte.sibF.index] << sibByte.sibF.scale;

  assign segData = seg[segSel];
  assign gprAll  = gpr;

endmodule

// ==== logic/instrFrontEnd.sv ====
`timescale 1ns/1ps

module instrFrontEnd (
  input  logic                               clk25,
  input  logic                               reset,
  output logic                               wbCyc,
  output logic                               wbStb,
  output logic [x86FrontPkg::physAddrW-1:0]  wbAdr,
  input  logic [7:0]                         wbDat,
  input  logic                               wbAck,
  output logic                               outValid,
  input  logic                               outReady,
  output x86FrontPkg::decodedInstr           outInstr
);

  // Fetch path
  logic                  fetchStart;
  x86FrontPkg::fetchReq  fetchRq;
  logic                  fetchDone;
  logic [31:0]           fetchData;
  // Prefix and opcode
  x86FrontPkg::prefixState prefix;
  logic                    byteStrobe;
  logic                    clearPrefix;
  // Address bytes and registers
  x86FrontPkg::addrByte modrmByte;
  x86FrontPkg::addrByte sibByte;
  x86FrontPkg::gprBank  gprAll;
  logic [31:0]          dispValue;
  logic [31:0]          scaledIndex;
  logic [31:0]          eaValue;
  logic [1:0]           dispBytes;
  logic [1:0]           segSel;
  logic [15:0]          segData;
  logic                 eaLoad;
  logic                 needSib;
  logic                 memOperand;
  logic [2:0]           regSel;
  logic [1:0]           regWidth;
  logic [31:0]          regData;

  decodeCtrl i_ctrl (
    .clk25, .reset, .fetchStart, .fetchRq, .fetchDone, .fetchData,
    .prefix, .byteStrobe, .clearPrefix,
    .modrmOut(modrmByte), .sibOut(sibByte), .dispOut(dispValue),
    .needSib, .memOperand, .dispBytes, .eaLoad, .eaValue, .segValue(segData),
    .regSel, .regWidth, .regData, .outValid, .outReady, .outInstr
  );

  prefixOpcodeDecode i_prefix (
    .clk25, .reset, .byteIn(fetchData[7:0]), .byteStrobe, .clearPrefix, .prefix
  );

  wbByteFetch i_fetch (
    .clk25, .reset, .fetchStart, .fetchRq, .fetchDone, .fetchData,
    .wbCyc, .wbStb, .wbAdr, .wbDat, .wbAck
  );

  gprFile i_gpr (
    .clk25, .reset, .regSel, .width(regWidth), .regData, .sibByte, .scaledIndex,
    .segSel, .segData, .gprAll
  );

  effAddrCalc i_ea (
    .clk25, .reset, .addrMode(modrmByte), .sibByte, .asize(prefix.asize), .prefix,
    .gprAll, .scaledIndex, .disp(dispValue), .eaLoad, .dispBytes, .eaValue,
    .segSelOut(segSel), .needSib, .memOperand
  );

endmodule

// ==== logic/prefixOpcodeDecode.sv ====
`timescale 1ns/1ps

module prefixOpcodeDecode (
  input  logic                    clk25,
  input  logic                    reset,
  input  logic [7:0]              byteIn,
  input  logic                    byteStrobe,
  input  logic                    clearPrefix,
  output x86FrontPkg::prefixState prefix
);

  // ModRM needed? Separate lists for the base and 0F sets
  function automatic logic modrmTable(input logic ext, input logic [7:0] op);
    logic hit;
    if (ext) begin
      casez (op)
        8'b0000_01??, 8'b0000_10??, 8'b0010_01?1, 8'b0011_10?1,
        8'b0011_0???, 8'b0011_11??, 8'b1000_????, 8'b1010_?00?,
        8'b1010_?010, 8'b1010_011?, 8'b1100_1???,
        8'h0C, 8'h0E, 8'hFF, 8'h77, 8'h7A, 8'h7B: hit = 1'b0;
        default: hit = 1'b1;  // Most 0F opcodes carry ModRM
      endcase
    end else begin
      casez (op)
        8'b00??_?0??,                             // ALU r/m forms
        8'b1000_????, 8'b1100_01??, 8'b1101_00??,
        8'b1101_1???,                             // FPU escapes
        8'b1111_?11?,
        8'h62, 8'h63, 8'h69, 8'h6B, 8'hC0, 8'hC1: hit = 1'b1;
        default: hit = 1'b0;
      endcase
    end
    return hit;
  endfunction

  always_ff @(posedge clk25) begin
    if (reset || clearPrefix) begin
      prefix <= '0;
    end else if (byteStrobe) begin
      case (byteIn)
        8'h0F: prefix.ext0F <= 1'b1;
        8'h26, 8'h2E, 8'h36, 8'h3E: begin
          prefix.segOverride <= 1'b1;
          prefix.segSel      <= byteIn[4:3];  // es cs ss ds
        end
        8'h66: prefix.osize <= ~prefix.osize;  // Toggle, not set
        8'h67: prefix.asize <= ~prefix.asize;
        8'hF2: prefix.repnz <= 1'b1;
        8'hF3: prefix.repz  <= 1'b1;
        8'hF0, 8'h64, 8'h65: ;                  // lock, fs, gs ignored
        default: begin
          prefix.opcode    <= byteIn;
          prefix.needModrm <= modrmTable(prefix.ext0F, byteIn);
        end
      endcase
    end
  end

endmodule

// ==== logic/wbByteFetch.sv ====
`timescale 1ns/1ps

module wbByteFetch (
  input  logic                              clk25,
  input  logic                              reset,
  input  logic                              fetchStart,
  input  x86FrontPkg::fetchReq              fetchRq,
  output logic                              fetchDone,
  output logic [31:0]                       fetchData,
  output logic                              wbCyc,
  output logic                              wbStb,
  output logic [x86FrontPkg::physAddrW-1:0] wbAdr,
  input  logic [7:0]                        wbDat,
  input  logic                              wbAck
);

  logic [1:0] byteIdx;  // Byte now on the bus
  logic [1:0] lastIdx;

  // Bus control
  always_ff @(posedge clk25) begin
    if (reset) begin
      wbCyc     <= 1'b0;
      wbStb     <= 1'b0;
      fetchDone <= 1'b0;
    end else begin
      fetchDone <= 1'b0;
      if (fetchStart) begin
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
      end else if (wbStb && wbAck) begin
        wbStb <= 1'b0;            // Gap before any next byte
        if (byteIdx == lastIdx) begin
          wbCyc     <= 1'b0;
          fetchDone <= 1'b1;
        end
      end else if (wbCyc && !wbStb) begin
        wbStb <= 1'b1;
      end
    end
  end

  // Address walk and little-endian assembly
  always_ff @(posedge clk25) begin
    if (fetchStart) begin
      wbAdr     <= fetchRq.addr;
      lastIdx   <= fetchRq.cntM1;
      byteIdx   <= 2'd0;
      fetchData <= 32'd0;          // Zero-extend short reads
    end else if (wbStb && wbAck) begin
      fetchData[8*byteIdx +: 8] <= wbDat;
      byteIdx <= byteIdx + 2'd1;
      wbAdr   <= wbAdr + 1'b1;     // Wraps at 1 MB
    end
  end

endmodule

// ==== logic/x86FrontPkg.sv ====
package x86FrontPkg;

  // ------------------------------
  // Widths and reset values
  // ------------------------------
  localparam int physAddrW = 20;  // cs*16 + ip, 1 MB space

  typedef logic [0:7][31:0] gprBank;  // eax ecx edx ebx esp ebp esi edi
  typedef logic [0:3][15:0] segBank;  // es cs ss ds

  localparam gprBank gprResetVal = {
    32'h7711_5544, 32'h0000_0000, 32'h0000_0000, 32'h0000_1122,
    32'h0000_7799, 32'h0000_0000, 32'h0000_2233, 32'h0000_0000
  };
  // ds and ss differ so the chosen segment shows in the address
  localparam segBank segResetVal = {16'h0000, 16'h0000, 16'h0200, 16'h0100};

  // Segment codes, same as prefix byte bits [4:3]
  localparam logic [1:0] segCs = 2'd1;
  localparam logic [1:0] segSs = 2'd2;
  localparam logic [1:0] segDs = 2'd3;

  // ------------------------------
  // Controller states
  // ------------------------------
  typedef enum logic [2:0] {
    INIT, PREFIX, MODRM, SIB, DISP, OPREAD, DONE
  } frontState;

  // ------------------------------
  // Shared records
  // ------------------------------
  typedef struct packed {
    logic [1:0] mode;
    logic [2:0] regIdx;
    logic [2:0] rm;
  } modrmFields;

  typedef struct packed {
    logic [1:0] scale;
    logic [2:0] index;
    logic [2:0] base;
  } sibFields;

  typedef union packed {
    modrmFields modrmF;
    sibFields   sibF;
  } addrByte;

  typedef struct packed {
    logic       ext0F;        // 0F seen
    logic       segOverride;
    logic [1:0] segSel;       // Override segment
    logic       osize;        // 66 toggle
    logic       asize;        // 67 toggle
    logic       repnz;
    logic       repz;
    logic [7:0] opcode;
    logic       needModrm;
  } prefixState;

  typedef struct packed {
    prefixState  prefix;
    addrByte     modrm;
    addrByte     sib;
    logic [31:0] ea;
    logic [15:0] segValue;
    logic        memOperand;  // r/m is in memory
    logic [31:0] op1;
    logic [31:0] op2;
    logic [15:0] nextIp;
  } decodedInstr;

  typedef struct packed {
    logic [physAddrW-1:0] addr;
    logic [1:0]           cntM1;  // Bytes minus one
  } fetchReq;

endpackage

// ==== verif/frontEnd_asserts.sv ====
`timescale 1ns/1ps

module frontEnd_asserts (
  input logic                              clk25,
  input logic                              reset,
  input logic                              wbCyc,
  input logic                              wbStb,
  input logic [x86FrontPkg::physAddrW-1:0] wbAdr,
  input logic                              wbAck,
  input logic                              outValid,
  input logic                              outReady,
  input x86FrontPkg::decodedInstr          outInstr
);

  // Strobe only inside a cycle
  stbInCyc: assert property (@(posedge clk25) disable iff (reset) wbStb |-> wbCyc)
    else $error("wbStb high while wbCyc low");

  // Address held until the slave acks
  adrHeld: assert property (@(posedge clk25) disable iff (reset)
    wbStb && !wbAck |=> wbStb && $stable(wbAdr))
    else $error("wbAdr or wbStb changed before ack");

  // Output record frozen under stall
  recordHeld: assert property (@(posedge clk25) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outInstr))
    else $error("record changed while stalled");

endmodule

bind instrFrontEnd frontEnd_asserts i_asserts (.*);

// ==== verif/instrFrontEndTb.sv ====
`timescale 1ns/1ps

module instrFrontEndTb;

  localparam int directedCount = 16;
  localparam int randomCount   = 200;
  localparam int totalCount    = directedCount + randomCount;
  localparam int waitLimit     = 1000;  // Cycles per record before giving up

  logic clk25;
  logic reset;
  logic wbCyc;
  logic wbStb;
  logic [x86FrontPkg::physAddrW-1:0] wbAdr;
  logic [7:0] wbDat;
  logic wbAck;
  logic outValid;
  logic outReady;
  x86FrontPkg::decodedInstr outInstr;

  logic [7:0] mem [0:(1<<20)-1];  // Wishbone slave contents
  x86FrontPkg::decodedInstr expQ[$];
  x86FrontPkg::decodedInstr expRec;
  int accepted;
  int ackWait;

  logic [7:0] prefixOps [11] = '{8'h26, 8'h2E, 8'h36, 8'h3E, 8'h66, 8'h67,
                                 8'hF2, 8'hF3, 8'hF0, 8'h64, 8'h65};
  logic [7:0] baseOps [12] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h88, 8'h89,
                               8'h8A, 8'h8B, 8'h90, 8'hC3, 8'h40, 8'h50};
  logic [7:0] extOps [4] = '{8'hB6, 8'hB7, 8'hAF, 8'h84};

  // Directed program, one instruction per line
  logic [7:0] directed[$] = {
    8'h90,
    8'h2E, 8'h66, 8'h67, 8'hF3, 8'h0F, 8'hB6, 8'hC0,
    8'h66, 8'h66, 8'h90,                              // osize toggles back
    8'h8B, 8'h42, 8'h05,                              // [bp+si+5]
    8'h8B, 8'h87, 8'h00, 8'hF0,                       // [bx+F000] wraps
    8'h67, 8'h8B, 8'h04, 8'h33,
    8'h67, 8'h8B, 8'h04, 8'h73,
    8'h67, 8'h8B, 8'h04, 8'hB3,
    8'h67, 8'h8B, 8'h04, 8'hF3,
    8'h67, 8'h8B, 8'h04, 8'h23,                       // No index
    8'h67, 8'h8B, 8'h04, 8'h35, 8'h78, 8'h56, 8'h34, 8'h12,
    8'h67, 8'h8B, 8'h44, 8'h75, 8'h08,                // ebp base, ss
    8'h8A, 8'hC4,                                     // al <- ah
    8'h88, 8'hDF,                                     // bh <- bl
    8'h8B, 8'hC6,
    8'h66, 8'h89, 8'hF0
  };

  instrFrontEnd i_dut (.*);

  initial clk25 = 1'b0;
  always #4 clk25 = ~clk25;

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic bit hasModrm(input bit ext, input logic [7:0] op);
    if (ext) return op inside {8'hB6, 8'hB7, 8'hAF};
    return op inside {[8'h00:8'h03], [8'h88:8'h8B]};
  endfunction

  function automatic logic [31:0] gprRead(input logic [2:0] sel, input int bits);
    if (bits == 8)
      return sel[2] ? {24'd0, x86FrontPkg::gprResetVal[sel[1:0]][15:8]}  // ah..bh
                    : {24'd0, x86FrontPkg::gprResetVal[sel][7:0]};
    if (bits == 16) return {16'd0, x86FrontPkg::gprResetVal[sel][15:0]};
    return x86FrontPkg::gprResetVal[sel];
  endfunction

  function automatic logic [31:0] memRead(input logic [19:0] addr, input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = mem[addr + 20'(i)];  // Wraps at 1 MB
    return v;
  endfunction

  function automatic x86FrontPkg::decodedInstr refDecode(input logic [15:0] startIp);
    x86FrontPkg::decodedInstr r;
    logic [15:0] ip;
    logic [7:0]  b;
    bit          done;
    bit          isMem;
    bit          ssRule;
    logic [1:0]  md;
    logic [2:0]  rmF;
    logic [2:0]  sBase;
    logic [31:0] disp;
    logic [31:0] base;
    logic [31:0] regV;
    logic [31:0] rmV;
    logic [1:0]  segCode;
    logic [19:0] opAddr;
    int          dlen;
    int          bits;
    r = '0;
    ip = startIp;
    done = 0;
    isMem = 0;
    ssRule = 0;
    while (!done) begin
      b = mem[ip];
      ip++;
      case (b)
        8'h0F: r.prefix.ext0F = 1'b1;
        8'h26, 8'h2E, 8'h36, 8'h3E: begin
          r.prefix.segOverride = 1'b1;
          r.prefix.segSel = b[4:3];
        end
        8'h66: r.prefix.osize = ~r.prefix.osize;
        8'h67: r.prefix.asize = ~r.prefix.asize;
        8'hF2: r.prefix.repnz = 1'b1;
        8'hF3: r.prefix.repz = 1'b1;
        8'hF0, 8'h64, 8'h65: ;
        default: begin
          r.prefix.opcode = b;
          done = 1;
        end
      endcase
    end
    r.prefix.needModrm = hasModrm(r.prefix.ext0F, b);
    bits = !b[0] ? 8 : (r.prefix.osize ? 32 : 16);
    if (r.prefix.needModrm) begin
      r.modrm = mem[ip];
      ip++;
      md = r.modrm.modrmF.mode;
      rmF = r.modrm.modrmF.rm;
      isMem = md != 2'b11;
      if (r.prefix.asize && isMem && rmF == 3'd4) begin
        r.sib = mem[ip];
        ip++;
      end
      sBase = r.sib.sibF.base;
      dlen = 0;
      if (isMem && md == 2'b01) dlen = 1;
      else if (isMem && md == 2'b10) dlen = r.prefix.asize ? 4 : 2;
      else if (md == 2'b00 && !r.prefix.asize && rmF == 3'd6) dlen = 2;
      else if (md == 2'b00 && r.prefix.asize && (rmF == 3'd5 || (rmF == 3'd4 && sBase == 3'd5)))
        dlen = 4;
      disp = memRead({4'h0, ip}, dlen);
      ip += 16'(dlen);
      if (dlen == 1) disp = {{24{disp[7]}}, disp[7:0]};
      if (dlen == 2) disp = {{16{disp[15]}}, disp[15:0]};
      if (!r.prefix.asize) begin
        case (rmF)
          3'd0: base = gprRead(3, 16) + gprRead(6, 16);
          3'd1: base = gprRead(3, 16) + gprRead(7, 16);
          3'd2: base = gprRead(5, 16) + gprRead(6, 16);
          3'd3: base = gprRead(5, 16) + gprRead(7, 16);
          3'd4: base = gprRead(6, 16);
          3'd5: base = gprRead(7, 16);
          3'd6: base = md == 2'b00 ? 32'd0 : gprRead(5, 16);
          default: base = gprRead(3, 16);
        endcase
        r.ea = {16'd0, base[15:0] + disp[15:0]};
        ssRule = rmF inside {3'd2, 3'd3} || (md inside {2'b01, 2'b10} && rmF == 3'd6);
      end else begin
        if (rmF == 3'd4) begin
          base = (sBase == 3'd5 && md == 2'b00) ? 32'd0 : x86FrontPkg::gprResetVal[sBase];
          if (r.sib.sibF.index != 3'd4)
            base += x86FrontPkg::gprResetVal[r.sib.sibF.index] << r.sib.sibF.scale;
        end else if (rmF == 3'd5) base = md == 2'b00 ? 32'd0 : x86FrontPkg::gprResetVal[5];
        else base = x86FrontPkg::gprResetVal[rmF];
        r.ea = base + disp;
        ssRule = md inside {2'b01, 2'b10} && (rmF == 3'd5 || (rmF == 3'd4 && sBase == 3'd5));
      end
    end
    segCode = (isMem && ssRule) ? x86FrontPkg::segSs : x86FrontPkg::segDs;
    if (r.prefix.segOverride) segCode = r.prefix.segSel;
    r.segValue = x86FrontPkg::segResetVal[segCode];
    r.memOperand = isMem;
    if (r.prefix.needModrm) begin
      opAddr = {r.segValue, 4'h0} + r.ea[19:0];
      regV = gprRead(r.modrm.modrmF.regIdx, bits);
      rmV = isMem ? memRead(opAddr, bits / 8) : gprRead(r.modrm.modrmF.rm, bits);
      r.op1 = b[1] ? regV : rmV;  // Direction bit
      r.op2 = b[1] ? rmV : regV;
    end
    if (!isMem) r.ea = 32'd0;
    r.nextIp = ip;
    return r;
  endfunction

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compareRecord(input x86FrontPkg::decodedInstr got,
                               input x86FrontPkg::decodedInstr exp);
    checkValue("prefix", 32'(got.prefix), 32'(exp.prefix));
    checkValue("modrm", 32'(got.modrm), 32'(exp.modrm));
    checkValue("sib", 32'(got.sib), 32'(exp.sib));
    checkValue("memOperand", 32'(got.memOperand), 32'(exp.memOperand));
    checkValue("ea", got.ea, exp.ea);  // Zero for register forms
    checkValue("segValue", 32'(got.segValue), 32'(exp.segValue));
    checkValue("op1", got.op1, exp.op1);
    checkValue("op2", got.op2, exp.op2);
    checkValue("nextIp", 32'(got.nextIp), 32'(exp.nextIp));
  endtask

  always @(posedge clk25) begin
    if (!reset && outValid && outReady) begin
      if (expQ.size() == 0) begin
        $display("Record accepted with no instruction left to expect");
        $display("TEST FAIL");
        $fatal(1, "extra record");
      end else begin
        expRec = expQ.pop_front();
        compareRecord(outInstr, expRec);
        accepted++;
      end
    end
  end

  // ------------------------------
  // Slave and sink on falling edge
  // ------------------------------
  always @(negedge clk25) begin
    if (reset) begin
      wbAck = 1'b0;
    end else if (wbAck) begin
      wbAck = 1'b0;                   // One ack per byte
    end else if (wbCyc && wbStb) begin
      if (ackWait == 0) begin
        wbDat = mem[wbAdr];
        wbAck = 1'b1;
        ackWait = $urandom % 4;
      end else ackWait--;
    end
  end

  always @(negedge clk25) begin
    if (!reset) outReady = ($urandom % 4) != 0;  // Stall one cycle in four
  end

  initial begin
    int wp;
    int last;
    int waited;
    logic [15:0] ip;
    logic [15:0] start;
    x86FrontPkg::decodedInstr r;
    void'($urandom(32'h2744ec9c));
    reset = 1'b1;
    wbDat = 8'h00;
    wbAck = 1'b0;
    outReady = 1'b0;
    accepted = 0;
    ackWait = 0;
    for (int a = 0; a < (1 << 20); a++)
      mem[a] = a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'hA5;
    foreach (directed[i]) mem[i] = directed[i];
    wp = directed.size();
    // Random program, length taken from the reference walk
    for (int n = 0; n < randomCount; n++) begin
      start = 16'(wp);
      repeat ($urandom % 3) begin
        mem[wp] = prefixOps[$urandom % 11];
        wp++;
      end
      if ($urandom % 4 == 0) begin
        mem[wp] = 8'h0F;
        wp++;
        mem[wp] = extOps[$urandom % 4];
      end else mem[wp] = baseOps[$urandom % 12];
      wp++;
      for (int k = 0; k < 6; k++) mem[wp + k] = 8'($urandom);
      r = refDecode(start);
      wp = r.nextIp;
    end
    ip = 16'd0;
    for (int n = 0; n < totalCount; n++) begin
      r = refDecode(ip);
      expQ.push_back(r);
      ip = r.nextIp;
    end
    repeat (10) @(negedge clk25);
    reset = 1'b0;
    while (accepted < totalCount) begin
      last = accepted;
      waited = 0;
      while (accepted == last) begin
        @(negedge clk25);
        waited++;
        if (waited > waitLimit) begin
          $display("Timeout waiting for record %0d from the front end", last);
          $display("TEST FAIL");
          $fatal(1, "front end stalled");
        end
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule
